//--- src/arith_pkg.sv
package arith_pkg;

    // operand and result width
    localparam int data_width = 32;

    // multiplier bits retired per cycle
    localparam int mul_step = 8;
    localparam int mul_cycles = data_width / mul_step;
    localparam int mul_count_width = $clog2(mul_cycles + 1);

    // one restoring step per quotient bit
    localparam int div_cycles = data_width;
    localparam int div_count_width = $clog2(div_cycles + 1);

    localparam int op_width = 2;

    localparam logic [op_width-1:0] op_mul  = 2'd0;  // low word of a * b
    localparam logic [op_width-1:0] op_divu = 2'd1;  // unsigned quotient
    localparam logic [op_width-1:0] op_divs = 2'd2;  // signed quotient, toward zero
    localparam logic [op_width-1:0] op_remu = 2'd3;  // unsigned remainder

endpackage

//--- src/queue_pkg.sv
package queue_pkg;

    // result words the queue can hold, head register included
    localparam int queue_depth = 8;

    localparam int queue_addr_width = $clog2(queue_depth);

    // one bit wider so a full queue is distinct from an empty one
    localparam int queue_count_width = queue_addr_width + 1;

endpackage

//--- src/shift_add_mul.sv
`timescale 1ns/10ps

module shift_add_mul (
    input  logic                           clk,
    input  logic                           start,
    input  logic [arith_pkg::data_width-1:0] a,
    input  logic [arith_pkg::data_width-1:0] b,
    output logic [arith_pkg::data_width-1:0] product,
    output logic                           ready
);

    import arith_pkg::*;

    logic [data_width-1:0]      a_reg;
    logic [data_width-1:0]      b_reg;
    logic [mul_count_width-1:0] count;
    logic [data_width-1:0]      a_top;
    logic [data_width-1:0]      partial;

    // top digit of the multiplier, zero extended to the word
    assign a_top = {{(data_width - mul_step){1'b0}}, a_reg[data_width-1 -: mul_step]};
    assign partial = b_reg * a_top;  // only the low word of the product is kept

    always_ff @(posedge clk) begin
        if (start) begin
            count <= mul_count_width'(mul_cycles);
        end else if (!ready) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_reg   <= a;
            b_reg   <= b;
            product <= '0;
        end else if (!ready) begin
            product <= (product << mul_step) + partial;
            a_reg   <= a_reg << mul_step;  // next digit moves to the top
        end
    end

    assign ready = (count == '0);

endmodule

//--- src/restoring_div.sv
`timescale 1ns/10ps

module restoring_div (
    input  logic                             clk,
    input  logic                             start,
    input  logic                             signed_op,
    input  logic [arith_pkg::data_width-1:0] a,
    input  logic [arith_pkg::data_width-1:0] b,
    output logic [arith_pkg::data_width-1:0] quotient,
    output logic [arith_pkg::data_width-1:0] remainder,
    output logic                             ready
);

    import arith_pkg::*;

    logic [data_width-1:0]      abs_a;
    logic [data_width-1:0]      abs_b;
    logic                       negate_in;
    logic [data_width-1:0]      divisor;
    logic                       negate;
    logic [2*data_width-1:0]    rem_quo;  // partial remainder above, dividend and quotient below
    logic [div_count_width-1:0] count;
    logic [data_width:0]        trial;
    logic [data_width+1:0]      diff;

    assign abs_a = (signed_op && a[data_width-1]) ? -a : a;
    assign abs_b = (signed_op && b[data_width-1]) ? -b : b;
    assign negate_in = signed_op && (a[data_width-1] ^ b[data_width-1]);

    // remainder shifted left with the next dividend bit, kept one bit wide
    // so that large unsigned divisors do not lose the top bit
    assign trial = rem_quo[2*data_width-1:data_width-1];
    assign diff = {1'b0, trial} - {2'b00, divisor};

    always_ff @(posedge clk) begin
        if (start) begin
            count <= div_count_width'(div_cycles);
        end else if (!ready) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            divisor <= abs_b;
            negate  <= negate_in;
            rem_quo <= {{data_width{1'b0}}, abs_a};
        end else if (!ready) begin
            if (diff[data_width+1]) begin
                // divisor does not fit, restore by keeping the shifted value
                rem_quo <= {rem_quo[2*data_width-2:0], 1'b0};
            end else begin
                rem_quo <= {diff[data_width-1:0], rem_quo[data_width-2:0], 1'b1};
            end
        end
    end

    // a zero divisor never borrows, so the magnitude comes out all ones
    assign quotient = negate ? -rem_quo[data_width-1:0] : rem_quo[data_width-1:0];
    assign remainder = rem_quo[2*data_width-1:data_width];
    assign ready = (count == '0);

endmodule

//--- src/result_ram.sv
`timescale 1ns/10ps

module result_ram (
    input  logic                                 clk,
    input  logic [queue_pkg::queue_addr_width-1:0] addr,
    input  logic [arith_pkg::data_width-1:0]     din,
    output logic [arith_pkg::data_width-1:0]     dout,
    input  logic                                 re,
    input  logic                                 we
);

    import queue_pkg::*;

    logic [arith_pkg::data_width-1:0] mem [queue_depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
    end

    // read data is registered and holds until the next read
    always_ff @(posedge clk) begin
        if (re) begin
            dout <= mem[addr];
        end
    end

endmodule

//--- src/result_fifo.sv
`timescale 1ns/10ps

module result_fifo (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [arith_pkg::data_width-1:0]       din,
    input  logic                                   we,
    input  logic                                   re,
    output logic [arith_pkg::data_width-1:0]       dout,
    output logic                                   avail,
    output logic                                   full,
    output logic [queue_pkg::queue_addr_width-1:0] ram_addr,
    output logic [arith_pkg::data_width-1:0]       ram_din,
    output logic                                   ram_we,
    output logic                                   ram_re,
    input  logic [arith_pkg::data_width-1:0]       ram_dout
);

    import queue_pkg::*;

    logic [queue_addr_width-1:0]  rd_ptr;
    logic [queue_addr_width-1:0]  wr_ptr;
    logic [queue_count_width-1:0] count;  // words in the RAM plus the held head
    logic                         fetching;
    logic                         head_held;
    logic                         ram_has_word;
    logic                         do_write;
    logic                         do_read;
    logic                         do_fetch;

    // the RAM output register serves as the head of the queue
    assign head_held = avail | fetching;
    assign ram_has_word = count > {{(queue_count_width - 1){1'b0}}, head_held};

    assign do_write = we && !full;
    assign do_read = re && avail;
    assign do_fetch = !do_write && !head_held && ram_has_word;  // a write owns the port

    assign ram_we = do_write;
    assign ram_re = do_fetch;
    assign ram_addr = do_write ? wr_ptr : rd_ptr;
    assign ram_din = din;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            fetching <= 1'b0;
            avail    <= 1'b0;
        end else begin
            fetching <= do_fetch;
            if (fetching) begin
                avail <= 1'b1;  // ram_dout now holds the oldest word
            end else if (do_read) begin
                avail <= 1'b0;
            end
            if (do_fetch) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full = (count == queue_count_width'(queue_depth));
    assign dout = ram_dout;

endmodule

//--- src/arith_unit.sv
`timescale 1ns/10ps

module arith_unit (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  logic [arith_pkg::op_width-1:0]   op,
    input  logic [arith_pkg::data_width-1:0] a,
    input  logic [arith_pkg::data_width-1:0] b,
    output logic                             busy,
    input  logic                             re,
    output logic [arith_pkg::data_width-1:0] dout,
    output logic                             avail
);

    import arith_pkg::*;
    import queue_pkg::*;

    logic                        running;
    logic [op_width-1:0]         op_reg;
    logic                        accept;
    logic                        mul_start;
    logic                        div_start;
    logic                        div_signed;
    logic                        mul_ready;
    logic                        div_ready;
    logic                        engine_ready;
    logic                        done;
    logic [data_width-1:0]       product;
    logic [data_width-1:0]       quotient;
    logic [data_width-1:0]       remainder;
    logic [data_width-1:0]       result_word;
    logic                        full;
    logic [queue_addr_width-1:0] ram_addr;
    logic [data_width-1:0]       ram_din;
    logic [data_width-1:0]       ram_dout;
    logic                        ram_we;
    logic                        ram_re;

    assign accept = start && !busy;  // starts while busy are dropped
    assign mul_start = accept && (op == op_mul);
    assign div_start = accept && (op != op_mul);
    assign div_signed = (op == op_divs);

    assign engine_ready = (op_reg == op_mul) ? mul_ready : div_ready;
    assign done = running && engine_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else if (accept) begin
            running <= 1'b1;
        end else if (done) begin
            running <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_reg <= op;
        end
    end

    always_comb begin
        case (op_reg)
            op_mul:  result_word = product;
            op_remu: result_word = remainder;
            default: result_word = quotient;
        endcase
    end

    // full keeps new commands out so the pending result always has a slot
    assign busy = running | full;

    shift_add_mul u_mul (
        .clk     (clk),
        .start   (mul_start),
        .a       (a),
        .b       (b),
        .product (product),
        .ready   (mul_ready)
    );

    restoring_div u_div (
        .clk       (clk),
        .start     (div_start),
        .signed_op (div_signed),
        .a         (a),
        .b         (b),
        .quotient  (quotient),
        .remainder (remainder),
        .ready     (div_ready)
    );

    result_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .din      (result_word),
        .we       (done),
        .re       (re),
        .dout     (dout),
        .avail    (avail),
        .full     (full),
        .ram_addr (ram_addr),
        .ram_din  (ram_din),
        .ram_we   (ram_we),
        .ram_re   (ram_re),
        .ram_dout (ram_dout)
    );

    result_ram u_ram (
        .clk  (clk),
        .addr (ram_addr),
        .din  (ram_din),
        .dout (ram_dout),
        .re   (ram_re),
        .we   (ram_we)
    );

endmodule

//--- tb/arith_unit_sva.sv
`timescale 1ns/10ps

module arith_unit_sva (
    input logic                                    clk,
    input logic                                    rst,
    input logic                                    start,
    input logic                                    busy,
    input logic                                    avail,
    input logic                                    running,
    input logic [queue_pkg::queue_count_width-1:0] fifo_count
);

    import queue_pkg::*;

    // reset clears the running flag and empties the queue
    reset_clears_outputs: assert property (@(posedge clk) rst |=> !busy && !avail)
        else $error("busy or avail high in the cycle after reset");

    // the write that fills the queue also ends the command, so no result waits for a slot
    full_queue_holds_busy: assert property (@(posedge clk) disable iff (rst)
        (fifo_count == queue_count_width'(queue_depth)) |-> busy && !running)
        else $error("queue is full while busy is low or an engine is still running");

    accept_sets_busy: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |=> busy)
        else $error("accepted start not followed by busy");

endmodule

bind arith_unit arith_unit_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .busy       (busy),
    .avail      (avail),
    .running    (running),
    .fifo_count (u_fifo.count)
);

//--- tb/arith_unit_tb.sv
`timescale 1ns/10ps

module arith_unit_tb;

    import arith_pkg::*;
    import queue_pkg::*;

    localparam int n_mul = 20;
    localparam int n_div = 26;
    localparam int n_sdiv = 17;
    localparam int n_fill = queue_depth;
    localparam int n_mixed = 24;
    localparam int num_cmds = n_mul + n_div + n_sdiv + n_fill + n_mixed;
    localparam int cycle_limit = num_cmds * 40 + 200;  // a divide plus its read fits in 40 cycles

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic [op_width-1:0]   op;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic                  busy;
    logic                  re;
    logic [data_width-1:0] dout;
    logic                  avail;

    logic [data_width-1:0] expected[$];  // results in issue order
    logic [data_width-1:0] head_word;
    int                    read_mode;    // 0 holds re low, 1 reads at random, 2 reads every cycle
    int                    test_errors;
    int                    pass_count;
    int                    fail_count;
    int                    cycle_count = 0;

    arith_unit DUT (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .op    (op),
        .a     (a),
        .b     (b),
        .busy  (busy),
        .re    (re),
        .dout  (dout),
        .avail (avail)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [data_width-1:0] ref_result(
        input logic [op_width-1:0]   op_code,
        input logic [data_width-1:0] x,
        input logic [data_width-1:0] y
    );
        logic [2*data_width-1:0] wide;
        logic [data_width-1:0]   mag_x;
        logic [data_width-1:0]   mag_y;
        logic [data_width-1:0]   mag_q;

        wide = {{data_width{1'b0}}, x} * {{data_width{1'b0}}, y};
        mag_x = x[data_width-1] ? -x : x;
        mag_y = y[data_width-1] ? -y : y;
        mag_q = (mag_y == '0) ? '1 : mag_x / mag_y;  // zero divisor gives an all ones magnitude
        case (op_code)
            op_mul:  return wide[data_width-1:0];
            op_divu: return (y == '0) ? '1 : x / y;
            op_divs: return (x[data_width-1] ^ y[data_width-1]) ? -mag_q : mag_q;
            default: return (y == '0) ? x : x % y;
        endcase
    endfunction

    // divisors of every size, small ones included
    function automatic logic [data_width-1:0] random_divisor();
        return $urandom >> $urandom_range(0, data_width - 1);
    endfunction

    task automatic issue_cmd(
        input logic [op_width-1:0]   cmd_op,
        input logic [data_width-1:0] x,
        input logic [data_width-1:0] y
    );
        while (busy) begin
            @(posedge clk);
            #2;
        end
        start = 1'b1;
        op = cmd_op;
        a = x;
        b = y;
        expected.push_back(ref_result(cmd_op, x, y));
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_idle();
        while (expected.size() != 0 || busy) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_busy(input logic want);
        if (busy !== want) begin
            $display("error busy: expected %h, got %h", want, busy);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        re = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            case (read_mode)
                1:       re = ($urandom_range(0, 3) != 0);
                2:       re = 1'b1;
                default: re = 1'b0;
            endcase
        end
    end

    // the word on dout is taken at the next rising edge
    always @(negedge clk) begin
        if (!rst && avail && re) begin
            if (expected.size() == 0) begin
                $display("queue returned word %h with no command outstanding", dout);
                test_errors++;
            end else begin
                head_word = expected.pop_front();
                if (dout !== head_word) begin
                    $display("error dout: expected %h, got %h", head_word, dout);
                    test_errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run hung and did not end within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int                    i;
        logic [data_width-1:0] y;
        logic [op_width-1:0]   cmd_op;

        void'($urandom(32'h9ce));
        rst = 1'b1;
        start = 1'b0;
        op = '0;
        a = '0;
        b = '0;
        read_mode = 0;
        test_errors = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        read_mode = 1;
        issue_cmd(op_mul, 32'h0000_0000, 32'h1234_5678);
        issue_cmd(op_mul, 32'hdead_beef, 32'h0000_0000);
        issue_cmd(op_mul, 32'hffff_ffff, 32'hffff_ffff);
        issue_cmd(op_mul, 32'hffff_ffff, 32'h0000_0002);
        for (i = 0; i < n_mul - 4; i++) begin
            issue_cmd(op_mul, $urandom, $urandom);
        end
        wait_idle();
        end_test("multiply");

        for (i = 0; i < (n_div - 2) / 2; i++) begin
            issue_cmd(op_divu, $urandom, random_divisor());
            issue_cmd(op_remu, $urandom, random_divisor());
        end
        issue_cmd(op_divu, 32'h8765_4321, 32'h0000_0000);
        issue_cmd(op_remu, 32'h8765_4321, 32'h0000_0000);
        wait_idle();
        end_test("unsigned divide and remainder");

        issue_cmd(op_divs, 32'h0000_0064, 32'h0000_0007);  // 100 / 7
        issue_cmd(op_divs, 32'hffff_ff9c, 32'h0000_0007);  // -100 / 7
        issue_cmd(op_divs, 32'h0000_0064, 32'hffff_fff9);
        issue_cmd(op_divs, 32'hffff_ff9c, 32'hffff_fff9);
        issue_cmd(op_divs, 32'h8000_0000, 32'hffff_ffff);  // wraps back to the most negative value
        for (i = 0; i < n_sdiv - 5; i++) begin
            y = random_divisor();
            if ($urandom_range(0, 1) == 1) begin
                y = -y;
            end
            issue_cmd(op_divs, $urandom, y);
        end
        wait_idle();
        end_test("signed divide");

        read_mode = 0;
        for (i = 0; i < n_fill; i++) begin
            cmd_op = op_width'($urandom_range(0, 3));
            issue_cmd(cmd_op, $urandom, random_divisor());
        end
        repeat (div_cycles + 2) @(posedge clk);  // last result is written by now
        #2;
        check_busy(1'b1);
        if (avail !== 1'b1) begin
            $display("oldest result is not available while the queue is full");
            test_errors++;
        end
        for (i = 0; i < 3; i++) begin
            start = 1'b1;
            op = op_mul;
            a = $urandom;
            b = $urandom;
            @(posedge clk);
            #2;
            check_busy(1'b1);
        end
        start = 1'b0;
        repeat (div_cycles + 2) begin
            @(posedge clk);
            #2;
            check_busy(1'b1);
        end
        read_mode = 2;
        wait_idle();
        repeat (4) begin
            @(posedge clk);
            #2;
            if (avail !== 1'b0) begin
                $display("queue still offers a word after all results were read");
                test_errors++;
            end
        end
        end_test("full queue back-pressure");

        read_mode = 1;
        for (i = 0; i < n_mixed; i++) begin
            cmd_op = op_width'($urandom_range(0, 3));
            issue_cmd(cmd_op, $urandom, (cmd_op == op_mul) ? $urandom : random_divisor());
            repeat ($urandom_range(0, 3)) begin
                @(posedge clk);
                #2;
            end
        end
        wait_idle();
        end_test("mixed commands with random reads");

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/arith_pkg.sv
src/queue_pkg.sv
src/shift_add_mul.sv
src/restoring_div.sv
src/result_ram.sv
src/result_fifo.sv
src/arith_unit.sv
tb/arith_unit_sva.sv
tb/arith_unit_tb.sv

//--- Makefile
TOP = arith_unit_tb

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
